/* Makefile */
# Verilator build and run of the carrier loop testbench

VERILATOR ?= verilator
TOP       := carrierLoopTb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(BUILD_DIR)

/* common/carrierLoopPkg.sv */
// carrier loop shared definitions
// sample, phase error, integrator and frequency offset widths and types
// used by the loop filter, lock detector, NCO and symbol aligner

package carrierLoopPkg;

    //--------------------------------------------------
    // widths
    //--------------------------------------------------

    // I/Q sample width
    parameter int sampleWidth = 18;

    // phase detector error
    parameter int errorWidth = 8;

    // lag integrator and filter sum, 8 fractional bits below the offset
    parameter int accumWidth = 40;

    // frequency offset and NCO phase
    parameter int offsetWidth = 32;

    // lead and lag gain exponents
    parameter int expWidth = 5;

    //--------------------------------------------------
    // types
    //--------------------------------------------------

    typedef logic signed [sampleWidth-1:0] sampleT;
    typedef logic signed [errorWidth-1:0]  errorT;
    typedef logic signed [accumWidth-1:0]  accumT;
    typedef logic signed [offsetWidth-1:0] offsetT;

endpackage

/* hw/carrierLoop/carrierLoop.sv */
// Trellis carrier recovery loop
// filters the phase error into a frequency offset, drives the NCO phase
// and realigns symbol enables and samples, slipping a symbol on lost lock

`timescale 1ns/1ps

module carrierLoop import carrierLoopPkg::*; #(
    parameter int lockCountWidth = 16,
    parameter int alignDepth = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      symEnEven,
    input  logic                      symEn,
    input  logic                      sym2xEn,
    input  sampleT                    iIn,
    input  sampleT                    qIn,
    input  errorT                     phaseError,
    input  logic                      errorEn,
    input  logic                      errorValid,
    input  logic                      invertError,
    input  logic                      zeroError,
    input  logic                      clearAccum,
    input  logic [expWidth-1:0]       leadExp,
    input  logic [expWidth-1:0]       lagExp,
    input  offsetT                    limit,
    input  logic [lockCountWidth-1:0] lockCount,
    input  logic [lockCountWidth-1:0] syncThreshold,
    output logic                      demodLock,
    output offsetT                    ncoFreq,
    output offsetT                    ncoPhase,
    output sampleT                    iOut,
    output sampleT                    qOut,
    output logic                      symEnEvenOut,
    output logic                      symEnOut,
    output logic                      sym2xEnOut
);

    offsetT freqOffset;
    logic   freqEn;
    logic   slipRequest;
    logic   slipDone;

    loopFilter filter (
        .clk        (clk),
        .reset      (reset),
        .errorEn    (errorEn),
        .phaseError (phaseError),
        .invertError(invertError),
        .zeroError  (zeroError),
        .clearAccum (clearAccum),
        .leadExp    (leadExp),
        .lagExp     (lagExp),
        .limit      (limit),
        .freqOffset (freqOffset),
        .freqEn     (freqEn)
    );

    lockDetector #(
        .lockCountWidth(lockCountWidth)
    ) lockDet (
        .clk          (clk),
        .reset        (reset),
        .errorEn      (errorEn),
        .errorValid   (errorValid),
        .phaseError   (phaseError),
        .lockCount    (lockCount),
        .syncThreshold(syncThreshold),
        .slipDone     (slipDone),
        .demodLock    (demodLock),
        .slipRequest  (slipRequest)
    );

    // offset crosses into the 2x symbol rate here
    ncoPhase nco (
        .clk       (clk),
        .reset     (reset),
        .sym2xEn   (sym2xEn),
        .freqEn    (freqEn),
        .freqOffset(freqOffset),
        .ncoFreq   (ncoFreq),
        .ncoPhase  (ncoPhase)
    );

    symbolAlign #(
        .alignDepth(alignDepth)
    ) aligner (
        .clk         (clk),
        .reset       (reset),
        .symEnEven   (symEnEven),
        .symEn       (symEn),
        .sym2xEn     (sym2xEn),
        .iIn         (iIn),
        .qIn         (qIn),
        .slipRequest (slipRequest),
        .slipDone    (slipDone),
        .iOut        (iOut),
        .qOut        (qOut),
        .symEnEvenOut(symEnEvenOut),
        .symEnOut    (symEnOut),
        .sym2xEnOut  (sym2xEnOut)
    );

endmodule

/* hw/carrierLoop/lockDetector.sv */
// Carrier lock detector
// up/down counter on the size of valid phase errors with hysteresis,
// holds a symbol slip request after a repeated loss of lock

`timescale 1ns/1ps

module lockDetector import carrierLoopPkg::*; #(
    parameter int lockCountWidth = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      errorEn,
    input  logic                      errorValid,
    input  errorT                     phaseError,
    input  logic [lockCountWidth-1:0] lockCount,
    input  logic [lockCountWidth-1:0] syncThreshold,
    input  logic                      slipDone,
    output logic                      demodLock,
    output logic                      slipRequest
);

    localparam logic [lockCountWidth-1:0] countTop = '1;

    logic                      validReg;
    logic [errorWidth-1:0]     absError;
    logic [errorWidth-1:0]     threshold;
    logic [lockCountWidth-1:0] lockCounter;
    logic                      badError;
    logic                      lockLost;
    logic                      lockGained;

    // only the low byte of the threshold matters
    assign threshold = errorWidth'(syncThreshold);

    // judged on the error from the previous strobe
    assign badError   = absError > threshold;
    assign lockLost   = badError && (lockCounter == countTop - lockCount);
    assign lockGained = !badError && (lockCounter == lockCount);

    always_ff @(posedge clk) begin
        if (errorEn) begin
            absError <= (phaseError < 0) ? -phaseError : phaseError;
        end
    end

    //--------------------------------------------------
    // lock counter
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            validReg    <= 1'b0;
            lockCounter <= '0;
            demodLock   <= 1'b1;
            slipRequest <= 1'b0;
        end else begin
            if (errorEn) begin
                validReg <= errorValid;
                if (validReg) begin
                    if (lockLost) begin
                        demodLock   <= 1'b0;
                        lockCounter <= '0;
                    end else if (lockGained) begin
                        demodLock   <= 1'b1;
                        lockCounter <= '0;
                    end else if (badError) begin
                        lockCounter <= lockCounter - 1'b1;
                    end else begin
                        lockCounter <= lockCounter + 1'b1;
                    end
                end
            end

            // slip only if we were already out of lock
            if (slipDone) begin
                slipRequest <= 1'b0;
            end else if (errorEn && validReg && lockLost && !demodLock) begin
                slipRequest <= 1'b1;
            end
        end
    end

endmodule

/* hw/carrierLoop/loopFilter.sv */
// Carrier loop filter
// conditions the phase error and runs a lead/lag filter with a limited
// lag integrator, producing a new frequency offset per error strobe

`timescale 1ns/1ps

module loopFilter import carrierLoopPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                errorEn,
    input  errorT               phaseError,
    input  logic                invertError,
    input  logic                zeroError,
    input  logic                clearAccum,
    input  logic [expWidth-1:0] leadExp,
    input  logic [expWidth-1:0] lagExp,
    input  offsetT              limit,
    output offsetT              freqOffset,
    output logic                freqEn
);

    localparam int fracWidth = accumWidth - offsetWidth;

    errorT                       loopError;
    logic                        filterEn;
    accumT                       leadTerm;
    accumT                       lagStep;
    accumT                       lagAccum;
    accumT                       lagNext;
    accumT                       filterSum;
    logic signed [accumWidth:0]  lagSum;
    logic signed [offsetWidth:0] lagTop;
    logic signed [offsetWidth:0] posLimit;
    logic signed [offsetWidth:0] negLimit;

    //--------------------------------------------------
    // error conditioning
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (errorEn) begin
            if (zeroError) begin
                loopError <= '0;
            end else if (invertError) begin
                loopError <= -phaseError;
            end else begin
                loopError <= phaseError;
            end
        end
    end

    //--------------------------------------------------
    // lead and lag gain
    //--------------------------------------------------

    // gains are powers of two
    assign leadTerm = accumT'(loopError) <<< leadExp;
    assign lagStep  = accumT'(loopError) <<< lagExp;

    // one guard bit so the clamp sees a true overflow
    assign lagSum   = lagAccum + lagStep;
    assign lagTop   = lagSum[accumWidth:fracWidth];
    assign posLimit = limit;
    assign negLimit = -posLimit;

    always_comb begin
        if (clearAccum) begin
            lagNext = '0;
        end else if (lagTop > posLimit) begin
            lagNext = {limit, {fracWidth{1'b0}}};
        end else if (lagTop < negLimit) begin
            lagNext = {negLimit[offsetWidth-1:0], {fracWidth{1'b0}}};
        end else begin
            lagNext = lagSum[accumWidth-1:0];
        end
    end

    //--------------------------------------------------
    // integrator and filter sum
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            filterEn  <= 1'b0;
            freqEn    <= 1'b0;
            lagAccum  <= '0;
            filterSum <= '0;
        end else begin
            filterEn <= errorEn;
            freqEn   <= filterEn;
            if (filterEn) begin
                lagAccum  <= lagNext;
                // clamped lag plus lead
                filterSum <= lagNext + leadTerm;
            end
        end
    end

    // drop the fractional bits
    assign freqOffset = filterSum[accumWidth-1:fracWidth];

endmodule

/* hw/carrierLoop/ncoPhase.sv */
// NCO frequency handoff and phase accumulator
// moves filter offsets into the 2x symbol domain and integrates them

`timescale 1ns/1ps

module ncoPhase import carrierLoopPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   sym2xEn,
    input  logic   freqEn,
    input  offsetT freqOffset,
    output offsetT ncoFreq,
    output offsetT ncoPhase
);

    offsetT savedOffset;
    logic   offsetSaved;

    //--------------------------------------------------
    // frequency handoff
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (freqEn && !sym2xEn) begin
            savedOffset <= freqOffset;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ncoFreq     <= '0;
            offsetSaved <= 1'b0;
        end else if (freqEn && sym2xEn) begin
            ncoFreq     <= freqOffset;
            offsetSaved <= 1'b0;
        end else if (freqEn) begin
            // hold until the next 2x symbol strobe
            offsetSaved <= 1'b1;
        end else if (sym2xEn && offsetSaved) begin
            ncoFreq     <= savedOffset;
            offsetSaved <= 1'b0;
        end
    end

    //--------------------------------------------------
    // phase accumulator
    //--------------------------------------------------

    // wraps modulo one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ncoPhase <= '0;
        end else if (sym2xEn) begin
            ncoPhase <= ncoPhase + ncoFreq;
        end
    end

endmodule

/* hw/symbolAlign.sv */
// Symbol aligner
// delays I/Q and the symbol enables to one output timing, swallows one
// symbol enable per slip request and keeps the even/odd symbol phase

`timescale 1ns/1ps

module symbolAlign import carrierLoopPkg::*; #(
    parameter int alignDepth = 2
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   symEnEven,
    input  logic   symEn,
    input  logic   sym2xEn,
    input  sampleT iIn,
    input  sampleT qIn,
    input  logic   slipRequest,
    output logic   slipDone,
    output sampleT iOut,
    output sampleT qOut,
    output logic   symEnEvenOut,
    output logic   symEnOut,
    output logic   sym2xEnOut
);

    logic [1:0] symEnEvenSr;
    logic [1:0] symEnSr;
    logic [1:0] sym2xEnSr;
    sampleT     iPipe [alignDepth];
    sampleT     qPipe [alignDepth];
    logic       evenSeeded;
    logic       dropSymbol;

    // first delayed symbol seen while a slip is pending
    assign dropSymbol = symEnSr[1] && slipRequest && !slipDone;

    //--------------------------------------------------
    // sample delay
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            iPipe[0] <= iIn;
            qPipe[0] <= qIn;
            for (int n = 1; n < alignDepth; n++) begin
                iPipe[n] <= iPipe[n-1];
                qPipe[n] <= qPipe[n-1];
            end
        end
        // reclock to the enable timing
        iOut <= iPipe[alignDepth-1];
        qOut <= qPipe[alignDepth-1];
    end

    //--------------------------------------------------
    // enables and slip gating
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            symEnEvenSr  <= '0;
            symEnSr      <= '0;
            sym2xEnSr    <= '0;
            sym2xEnOut   <= 1'b0;
            symEnOut     <= 1'b0;
            slipDone     <= 1'b0;
            symEnEvenOut <= 1'b0;
            evenSeeded   <= 1'b0;
        end else begin
            symEnEvenSr <= {symEnEvenSr[0], symEnEven};
            symEnSr     <= {symEnSr[0], symEn};
            sym2xEnSr   <= {sym2xEnSr[0], sym2xEn};

            sym2xEnOut <= sym2xEnSr[1];
            symEnOut   <= symEnSr[1] && !dropSymbol;
            slipDone   <= dropSymbol;

            // first symbol after reset takes its phase from symEnEven
            if (symEnOut) begin
                symEnEvenOut <= ~symEnEvenOut;
            end else if (!evenSeeded && symEnSr[1] && !dropSymbol) begin
                symEnEvenOut <= ~symEnEvenSr[1];
                evenSeeded   <= 1'b1;
            end
        end
    end

endmodule

/* tb/carrierLoopTb.sv */
// Carrier loop testbench
// random strobes, samples and phase errors through the lead path,
// integrator limit and a lock loss that ends in a symbol slip

`timescale 1ns/1ps

module carrierLoopTb import carrierLoopPkg::*; ();

    localparam int          clockPeriod = 20;
    localparam logic [31:0] seed        = 32'had2d;
    localparam int          lockTimeout = 3000;
    localparam int          slipTimeout = 6000;

    // phase error patterns
    localparam int smallError = 0;
    localparam int posError   = 1;
    localparam int negError   = 2;
    localparam int badError   = 3;

    logic                clk;
    logic                reset;
    logic                symEnEven;
    logic                symEn;
    logic                sym2xEn;
    sampleT              iIn;
    sampleT              qIn;
    errorT               phaseError;
    logic                errorEn;
    logic                errorValid;
    logic                invertError;
    logic                zeroError;
    logic                clearAccum;
    logic [expWidth-1:0] leadExp;
    logic [expWidth-1:0] lagExp;
    offsetT              limit;
    logic [15:0]         lockCount;
    logic [15:0]         syncThreshold;
    logic                demodLock;
    offsetT              ncoFreq;
    offsetT              ncoPhase;
    sampleT              iOut;
    sampleT              qOut;
    logic                symEnEvenOut;
    logic                symEnOut;
    logic                sym2xEnOut;

    logic [31:0] rnd;
    int          cycleCount;
    int          errorMode;
    logic        validOn;
    logic [2:0]  symEnHist;
    logic        symbolDropped;

    carrierLoop #(
        .lockCountWidth(16),
        .alignDepth    (2)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(clockPeriod / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic errorT nextError(input int mode, input logic [7:0] bits);
        errorT big;
        big = errorT'({2'b01, bits[5:0]});
        case (mode)
            posError: return big;
            negError: return -big;
            badError: return bits[7] ? -big : big;
            default:  return errorT'($signed(bits[4:0]));
        endcase
    endfunction

    // one clock of stimulus, driven just after the edge
    task automatic stepCycle();
        @(posedge clk);
        #1;
        // symEn driven three steps back missing on symEnOut
        if (symEnHist[2] && !symEnOut) begin
            symbolDropped = 1'b1;
        end
        cycleCount++;
        sym2xEn   = (cycleCount % 4) == 0;
        symEn     = (cycleCount % 8) == 0;
        symEnEven = (cycleCount % 16) == 0;
        symEnHist = {symEnHist[1:0], symEn};
        rnd = xorshift(rnd);
        iIn = sampleT'(rnd[17:0]);
        rnd = xorshift(rnd);
        qIn = sampleT'(rnd[31:14]);
        rnd = xorshift(rnd);
        errorEn    = rnd[1:0] == 2'b00;
        errorValid = validOn;
        phaseError = nextError(errorMode, rnd[15:8]);
    endtask

    task automatic runCycles(input int count);
        repeat (count) stepCycle();
    endtask

    task automatic waitLockLoss();
        int count;
        count = 0;
        while (demodLock && count < lockTimeout) begin
            stepCycle();
            count++;
        end
        if (demodLock) begin
            $display("** FAIL **");
            $fatal(1, "timeout: demodLock never dropped under large phase errors");
        end
    endtask

    task automatic waitSymbolDrop();
        int count;
        count = 0;
        while (!symbolDropped && count < slipTimeout) begin
            stepCycle();
            count++;
        end
        if (!symbolDropped) begin
            $display("** FAIL **");
            $fatal(1, "timeout: no symbol enable was slipped after lock loss");
        end
    endtask

    // any checker assertion ends the run
    always @(posedge clk) begin
        if (DUT.chk.failCount != 0) begin
            $display("** FAIL **");
            $fatal(1, "the bound checker reported an assertion failure");
        end
    end

    initial begin
        reset = 1'b1;
        {symEnEven, symEn, sym2xEn, errorEn, errorValid} = '0;
        iIn = '0;
        qIn = '0;
        phaseError = '0;
        invertError = 1'b0;
        zeroError = 1'b0;
        clearAccum = 1'b1;
        leadExp = 5'd10;
        lagExp = 5'd12;
        limit = 32'sd20000;
        lockCount = 16'd8;
        syncThreshold = 16'd40;
        rnd = seed;
        cycleCount = 0;
        errorMode = smallError;
        validOn = 1'b0;
        symEnHist = '0;
        symbolDropped = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // lead path with the integrator held clear
        validOn = 1'b1;
        runCycles(200);
        invertError = 1'b1;
        runCycles(200);
        zeroError = 1'b1;
        runCycles(100);
        invertError = 1'b0;
        zeroError = 1'b0;

        // drive the integrator into the limit, both signs
        clearAccum = 1'b0;
        validOn = 1'b0;
        errorMode = posError;
        runCycles(400);
        zeroError = 1'b1;
        runCycles(100);
        zeroError = 1'b0;
        errorMode = negError;
        runCycles(400);
        zeroError = 1'b1;
        runCycles(100);
        zeroError = 1'b0;

        // large valid errors until lock is lost and a symbol slips
        clearAccum = 1'b1;
        validOn = 1'b1;
        errorMode = badError;
        waitLockLoss();
        waitSymbolDrop();
        runCycles(50);

        if (DUT.chk.failCount != 0) begin
            $display("** FAIL **");
            $fatal(1, "the bound checker reported an assertion failure");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* tb/carrierLoop_chk.sv */
// Carrier loop checker
// concurrent assertions on enable alignment, sample delay, filter lead
// path, integrator limit, NCO phase and symbol slip gating

`timescale 1ns/1ps

module carrierLoop_chk import carrierLoopPkg::*; #(
    parameter int alignDepth = 2
) (
    input logic                clk,
    input logic                reset,
    input logic                symEn,
    input logic                sym2xEn,
    input sampleT              iIn,
    input sampleT              qIn,
    input errorT               phaseError,
    input logic                errorEn,
    input logic                invertError,
    input logic                zeroError,
    input logic                clearAccum,
    input logic [expWidth-1:0] leadExp,
    input offsetT              limit,
    input offsetT              freqOffset,
    input logic                freqEn,
    input logic                demodLock,
    input logic                slipRequest,
    input offsetT              ncoFreq,
    input offsetT              ncoPhase,
    input sampleT              iOut,
    input sampleT              qOut,
    input logic                symEnEvenOut,
    input logic                symEnOut,
    input logic                sym2xEnOut
);

    int     failCount = 0;
    int     fillCount;
    sampleT recI [alignDepth];
    sampleT recQ [alignDepth];

    // lead term alone, top offset bits of the shifted conditioned error
    function automatic offsetT leadOffset(input errorT err, input logic inv,
                                          input logic zero, input logic [expWidth-1:0] sh);
        errorT cond;
        accumT wide;
        cond = zero ? errorT'(0) : (inv ? errorT'(-err) : err);
        wide = accumT'(cond) * (accumT'(1) << sh);
        return wide[accumWidth-1:accumWidth-offsetWidth];
    endfunction

    //--------------------------------------------------
    // samples captured on each 2x symbol strobe
    //--------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            fillCount <= 0;
        end else if (sym2xEn && fillCount < alignDepth) begin
            fillCount <= fillCount + 1;
        end
    end

    always_ff @(posedge clk) begin
        if (sym2xEn) begin
            recI[0] <= iIn;
            recQ[0] <= qIn;
            for (int n = 1; n < alignDepth; n++) begin
                recI[n] <= recI[n-1];
                recQ[n] <= recQ[n-1];
            end
        end
    end

    //--------------------------------------------------
    // enables
    //--------------------------------------------------

    alignSym2x: assert property (@(posedge clk) disable iff (reset)
        sym2xEnOut == $past(sym2xEn, 3))
    else begin
        failCount++;
        $error("Mismatch at %0t: sym2xEnOut is %b, expected %b",
            $time, sym2xEnOut, $past(sym2xEn, 3));
    end

    alignSym: assert property (@(posedge clk) disable iff (reset)
        symEnOut |-> $past(symEn, 3))
    else begin
        failCount++;
        $error("symEnOut pulsed at %0t with no symEn three cycles before", $time);
    end

    evenToggle: assert property (@(posedge clk) disable iff (reset)
        symEnOut |=> symEnEvenOut != $past(symEnEvenOut))
    else begin
        failCount++;
        $error("Mismatch at %0t: symEnEvenOut is %b, expected %b",
            $time, symEnEvenOut, !$past(symEnEvenOut));
    end

    samplePath: assert property (@(posedge clk) disable iff (reset)
        fillCount >= alignDepth |=>
            iOut == $past(recI[alignDepth-1]) && qOut == $past(recQ[alignDepth-1]))
    else begin
        failCount++;
        $error("Mismatch at %0t: iOut/qOut are %0d/%0d, expected %0d/%0d", $time,
            iOut, qOut, $past(recI[alignDepth-1]), $past(recQ[alignDepth-1]));
    end

    //--------------------------------------------------
    // loop filter
    //--------------------------------------------------

    freqEnDelay: assert property (@(posedge clk) disable iff (reset)
        freqEn == $past(errorEn, 2))
    else begin
        failCount++;
        $error("Mismatch at %0t: freqEn is %b, expected %b",
            $time, freqEn, $past(errorEn, 2));
    end

    // integrator cleared, so only the lead term remains
    leadPath: assert property (@(posedge clk) disable iff (reset)
        freqEn && $past(clearAccum) |-> freqOffset == leadOffset($past(phaseError, 2),
            $past(invertError, 2), $past(zeroError, 2), $past(leadExp)))
    else begin
        failCount++;
        $error("Mismatch at %0t: freqOffset is %0d, expected %0d", $time, freqOffset,
            leadOffset($past(phaseError, 2), $past(invertError, 2),
                $past(zeroError, 2), $past(leadExp)));
    end

    lagLimit: assert property (@(posedge clk) disable iff (reset)
        freqEn && $past(zeroError, 2) |-> freqOffset <= limit && freqOffset >= -limit)
    else begin
        failCount++;
        $error("Mismatch at %0t: freqOffset is %0d, expected within +/-%0d",
            $time, freqOffset, limit);
    end

    //--------------------------------------------------
    // NCO
    //--------------------------------------------------

    phaseStep: assert property (@(posedge clk) disable iff (reset)
        sym2xEn |=> ncoPhase == offsetT'($past(ncoPhase) + $past(ncoFreq)))
    else begin
        failCount++;
        $error("Mismatch at %0t: ncoPhase is %0d, expected %0d",
            $time, ncoPhase, offsetT'($past(ncoPhase) + $past(ncoFreq)));
    end

    ncoHold: assert property (@(posedge clk) disable iff (reset)
        !sym2xEn |=> $stable(ncoPhase) && $stable(ncoFreq))
    else begin
        failCount++;
        $error("ncoPhase or ncoFreq changed at %0t without a sym2xEn before", $time);
    end

    //--------------------------------------------------
    // lock and slip
    //--------------------------------------------------

    lockAtReset: assert property (@(posedge clk) $fell(reset) |-> demodLock)
    else begin
        failCount++;
        $error("Mismatch at %0t: demodLock is %b after reset, expected 1",
            $time, demodLock);
    end

    slipGate: assert property (@(posedge clk) disable iff (reset)
        $past(symEn, 3) && !symEnOut |-> $past(slipRequest))
    else begin
        failCount++;
        $error("symbol enable swallowed at %0t with no slip request pending", $time);
    end

endmodule

bind carrierLoop carrierLoop_chk #(.alignDepth(alignDepth)) chk (.*);

/* verilog.f */
common/carrierLoopPkg.sv
hw/carrierLoop/loopFilter.sv
hw/carrierLoop/lockDetector.sv
hw/carrierLoop/ncoPhase.sv
hw/symbolAlign.sv
hw/carrierLoop/carrierLoop.sv
tb/carrierLoop_chk.sv
tb/carrierLoopTb.sv
